// ==== div_pkg.sv ====
package div_pkg;

    typedef logic [31:0] word_t;

    // operand interpretation
    typedef enum logic {
        DIV_UNSIGNED = 1'b0,
        DIV_SIGNED   = 1'b1
    } div_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_ITERATE  = 2'd1,
        ST_CORRECT  = 2'd2,
        ST_SIGN_FIX = 2'd3
    } div_state_e;

    // byte offsets of the register block
    typedef enum logic [4:0] {
        REG_DIVIDEND  = 5'h00,
        REG_DIVISOR   = 5'h04,
        REG_CTRL      = 5'h08,
        REG_STATUS    = 5'h0C,
        REG_QUOTIENT  = 5'h10,
        REG_REMAINDER = 5'h14
    } reg_addr_e;

    localparam int DIV_STEPS  = 32; // one quotient bit per cycle
    localparam int STEP_CNT_W = 6;  // holds DIV_STEPS

    // control word
    localparam int CTRL_MODE_BIT   = 0;
    localparam int CTRL_IRQ_EN_BIT = 1;

    // status word
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

endpackage

// ==== div_if.sv ====
`timescale 1ns/10ps

interface div_if;

    logic              start;     // one cycle, only while idle
    div_pkg::div_mode_e mode;
    div_pkg::word_t    dividend;
    div_pkg::word_t    divisor;

    logic              busy;
    logic              done;      // one cycle
    div_pkg::word_t    quotient;
    div_pkg::word_t    remainder;

    modport regs (
        output start, mode, dividend, divisor,
        input  busy, done, quotient, remainder
    );

    modport core (
        input  start, mode, dividend, divisor,
        output busy, done, quotient, remainder
    );

endinterface

// ==== div_core.sv ====
`timescale 1ns/10ps

module div_core (
    input logic clk_i,
    input logic rst_i,
    div_if.core div_port
);

    div_pkg::div_state_e            state_q;
    div_pkg::div_mode_e             mode_q;
    logic [div_pkg::STEP_CNT_W-1:0] cnt_q;
    logic [32:0]                    acc_q;    // partial remainder, bit 32 is the sign
    div_pkg::word_t                 quo_q;    // dividend shifts out, quotient shifts in
    div_pkg::word_t                 dvs_q;    // divisor magnitude
    logic                           neg_dvd_q;
    logic                           neg_dvs_q;

    logic           is_signed;
    logic           div_zero;
    logic           sgn_ovf;
    logic           early_out;
    logic           dvd_neg;
    logic           dvs_neg;
    div_pkg::word_t dvd_mag;
    div_pkg::word_t dvs_mag;
    logic [32:0]    acc_shl;
    logic [32:0]    acc_step;
    logic [32:0]    acc_fix;
    div_pkg::word_t quo_last;

    assign div_port.busy = (state_q != div_pkg::ST_IDLE);

    // special cases, checked on start
    assign is_signed = (div_port.mode == div_pkg::DIV_SIGNED);
    assign div_zero  = (div_port.divisor == '0);
    assign sgn_ovf   = is_signed && (div_port.dividend == 32'h8000_0000)
                       && (div_port.divisor == '1);
    assign early_out = !is_signed && (div_port.divisor > div_port.dividend);

    assign dvd_neg = is_signed && div_port.dividend[31];
    assign dvs_neg = is_signed && div_port.divisor[31];
    assign dvd_mag = dvd_neg ? -div_port.dividend : div_port.dividend;
    assign dvs_mag = dvs_neg ? -div_port.divisor : div_port.divisor;

    // one non-restoring step
    assign acc_shl  = {acc_q[31:0], quo_q[31]};
    assign acc_step = acc_q[32] ? acc_shl + {1'b0, dvs_q}
                                : acc_shl - {1'b0, dvs_q};

    // final restore and last quotient bit
    assign acc_fix  = acc_q[32] ? acc_q + {1'b0, dvs_q} : acc_q;
    assign quo_last = {quo_q[30:0], ~acc_q[32]};

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q            <= div_pkg::ST_IDLE;
            mode_q             <= div_pkg::DIV_UNSIGNED;
            cnt_q              <= '0;
            acc_q              <= '0;
            quo_q              <= '0;
            dvs_q              <= '0;
            neg_dvd_q          <= 1'b0;
            neg_dvs_q          <= 1'b0;
            div_port.done      <= 1'b0;
            div_port.quotient  <= '0;
            div_port.remainder <= '0;
        end else begin
            div_port.done <= 1'b0;
            case (state_q)
                div_pkg::ST_IDLE: begin
                    if (div_port.start) begin
                        mode_q <= div_port.mode;
                        if (div_zero) begin
                            div_port.quotient  <= '1;
                            div_port.remainder <= div_port.dividend;
                            div_port.done      <= 1'b1;
                        end else if (sgn_ovf) begin
                            div_port.quotient  <= div_port.dividend;
                            div_port.remainder <= '0;
                            div_port.done      <= 1'b1;
                        end else if (early_out) begin
                            div_port.quotient  <= '0;
                            div_port.remainder <= div_port.dividend;
                            div_port.done      <= 1'b1;
                        end else begin
                            acc_q     <= '0;
                            quo_q     <= dvd_mag;
                            dvs_q     <= dvs_mag;
                            neg_dvd_q <= dvd_neg;
                            neg_dvs_q <= dvs_neg;
                            cnt_q     <= div_pkg::STEP_CNT_W'(div_pkg::DIV_STEPS);
                            state_q   <= div_pkg::ST_ITERATE;
                        end
                    end
                end
                div_pkg::ST_ITERATE: begin
                    acc_q <= acc_step;
                    quo_q <= {quo_q[30:0], ~acc_q[32]}; // bit of the previous step
                    cnt_q <= cnt_q - div_pkg::STEP_CNT_W'(1);
                    if (cnt_q == div_pkg::STEP_CNT_W'(1)) begin
                        state_q <= div_pkg::ST_CORRECT;
                    end
                end
                div_pkg::ST_CORRECT: begin
                    if (mode_q == div_pkg::DIV_SIGNED) begin
                        acc_q   <= acc_fix;
                        quo_q   <= quo_last;
                        state_q <= div_pkg::ST_SIGN_FIX;
                    end else begin
                        div_port.quotient  <= quo_last;
                        div_port.remainder <= acc_fix[31:0];
                        div_port.done      <= 1'b1;
                        state_q            <= div_pkg::ST_IDLE;
                    end
                end
                div_pkg::ST_SIGN_FIX: begin
                    // quotient truncates toward zero, remainder follows dividend
                    div_port.quotient  <= (neg_dvd_q ^ neg_dvs_q) ? -quo_q : quo_q;
                    div_port.remainder <= neg_dvd_q ? -acc_q[31:0] : acc_q[31:0];
                    div_port.done      <= 1'b1;
                    state_q            <= div_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== div_regs.sv ====
`timescale 1ns/10ps

module div_regs (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  div_pkg::reg_addr_e wb_adr_i,
    input  div_pkg::word_t     wb_dat_i,
    output div_pkg::word_t     wb_dat_o,
    output logic               wb_ack_o,
    output logic               irq_o,
    div_if.regs                div_port
);

    div_pkg::word_t dividend_q;
    div_pkg::word_t divisor_q;
    div_pkg::word_t ctrl_q;
    div_pkg::word_t quot_q;
    div_pkg::word_t rem_q;
    div_pkg::word_t status;
    div_pkg::word_t rd_data;
    logic           done_q;   // sticky
    logic           start_q;
    logic           req;
    logic           wr_req;
    logic           ctrl_go;

    assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o; // no wait states
    assign wr_req  = req && wb_we_i;
    assign ctrl_go = wr_req && (wb_adr_i == div_pkg::REG_CTRL) && !div_port.busy;

    assign div_port.start    = start_q;
    assign div_port.mode     = div_pkg::div_mode_e'(ctrl_q[div_pkg::CTRL_MODE_BIT]);
    assign div_port.dividend = dividend_q;
    assign div_port.divisor  = divisor_q;

    assign irq_o = done_q && ctrl_q[div_pkg::CTRL_IRQ_EN_BIT];

    always_comb begin
        status                         = '0;
        status[div_pkg::STAT_BUSY_BIT] = div_port.busy;
        status[div_pkg::STAT_DONE_BIT] = done_q;
    end

    always_comb begin
        case (wb_adr_i)
            div_pkg::REG_DIVIDEND:  rd_data = dividend_q;
            div_pkg::REG_DIVISOR:   rd_data = divisor_q;
            div_pkg::REG_CTRL:      rd_data = ctrl_q;
            div_pkg::REG_STATUS:    rd_data = status;
            div_pkg::REG_QUOTIENT:  rd_data = quot_q;
            div_pkg::REG_REMAINDER: rd_data = rem_q;
            default:                rd_data = '0; // unmapped
        endcase
    end

    // bus handshake and read data
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= req;
            if (req && !wb_we_i) begin
                wb_dat_o <= rd_data;
            end
        end
    end

    // operand and control registers
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            dividend_q <= '0;
            divisor_q  <= '0;
            ctrl_q     <= '0;
            start_q    <= 1'b0;
        end else begin
            start_q <= ctrl_go; // lines up with the ack
            if (wr_req && (wb_adr_i == div_pkg::REG_DIVIDEND)) begin
                dividend_q <= wb_dat_i;
            end
            if (wr_req && (wb_adr_i == div_pkg::REG_DIVISOR)) begin
                divisor_q <= wb_dat_i;
            end
            if (ctrl_go) begin
                ctrl_q <= wb_dat_i;
            end
        end
    end

    // results and sticky done
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            quot_q <= '0;
            rem_q  <= '0;
            done_q <= 1'b0;
        end else begin
            if (div_port.done) begin
                quot_q <= div_port.quotient;
                rem_q  <= div_port.remainder;
            end
            if (start_q) begin
                done_q <= 1'b0;
            end else if (div_port.done) begin
                done_q <= 1'b1;
            end
        end
    end

endmodule

// ==== div_top.sv ====
`timescale 1ns/10ps

module div_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_adr_i,  // byte address
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        irq_o
);

    div_if div_bus ();

    div_regs u_regs (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (div_pkg::reg_addr_e'(wb_adr_i)),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .irq_o    (irq_o),
        .div_port (div_bus.regs)
    );

    div_core u_core (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .div_port (div_bus.core)
    );

endmodule

// ==== div_properties.sv ====
`timescale 1ns/10ps

module div_properties (
    input logic clk_i,
    input logic rst_i,
    input logic wb_ack_i,
    input logic start_i,
    input logic busy_i,
    input logic done_i
);

    // no wait states, so ack lasts one cycle
    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_i)
        wb_ack_i |=> !wb_ack_i)
        else $error("wb_ack_o high for two cycles in a row");

    done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_i |=> !done_i)
        else $error("done held longer than one cycle");

    done_ends_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_i |-> !busy_i && $past(busy_i || start_i))
        else $error("done without a start or busy phase before it");

    start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        start_i |-> !busy_i)
        else $error("start issued while the core is busy");

endmodule

// ==== tb_div_top.sv ====
`timescale 1ns/10ps

module tb_div_top;

    localparam int CLK_PERIOD = 4;
    localparam int N_RANDOM   = 6;
    localparam int MAX_POLLS  = 64;
    localparam int ACK_WAIT   = 16;

    logic           clk_i;
    logic           rst_i;
    logic           wb_cyc_i;
    logic           wb_stb_i;
    logic           wb_we_i;
    logic [4:0]     wb_adr_i;
    div_pkg::word_t wb_dat_i;
    div_pkg::word_t wb_dat_o;
    logic           wb_ack_o;
    logic           irq_o;

    div_pkg::div_mode_e pat_mode[$];
    div_pkg::word_t     pat_dvd[$];
    div_pkg::word_t     pat_dvs[$];
    div_pkg::word_t     pat_quo[$];
    div_pkg::word_t     pat_rem[$];

    int     n_tests = 0;
    int     n_errors = 0;
    int     n_failed_tests = 0;
    integer seed;

    div_top DUT (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .irq_o    (irq_o)
    );

    bind div_top div_properties u_props (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_ack_i (wb_ack_o),
        .start_i  (div_bus.start),
        .busy_i   (div_bus.busy),
        .done_i   (div_bus.done)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        wait (n_tests > 0);
        #((n_tests + 4) * 50 * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Verification failed");
        $finish;
    end

    // one classic cycle sampled on the falling edge
    task automatic wb_access(input logic we, input div_pkg::reg_addr_e addr,
                             input div_pkg::word_t wdata, output div_pkg::word_t rdata);
        int waited = 0;
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= addr;
        wb_dat_i <= wdata;
        @(negedge clk_i);
        while (!wb_ack_o && waited < ACK_WAIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!wb_ack_o) begin
            $display("no ack from the DUT for an access to offset %h", addr);
            n_errors++;
        end
        rdata = wb_dat_o;
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic wb_write(input div_pkg::reg_addr_e addr, input div_pkg::word_t data);
        div_pkg::word_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input div_pkg::reg_addr_e addr, output div_pkg::word_t data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic check_word(input string name, input div_pkg::word_t exp,
                              input div_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            n_errors++;
        end
    endtask

    task automatic check_status(input string name, input logic exp_busy,
                                input logic exp_done, input div_pkg::word_t act);
        div_pkg::word_t exp;
        exp                         = '0;
        exp[div_pkg::STAT_BUSY_BIT] = exp_busy;
        exp[div_pkg::STAT_DONE_BIT] = exp_done;
        if (act !== exp) begin
            $display("FAIL %s status: expected %h, actual %h", name, exp, act);
            n_errors++;
        end
    endtask

    task automatic check_irq(input string name, input logic exp);
        if (irq_o !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, irq_o);
            n_errors++;
        end
    endtask

    task automatic wait_done(input string name, output div_pkg::word_t status);
        int polls = 0;
        wb_read(div_pkg::REG_STATUS, status);
        while (!status[div_pkg::STAT_DONE_BIT] && polls < MAX_POLLS) begin
            wb_read(div_pkg::REG_STATUS, status);
            polls++;
        end
        if (!status[div_pkg::STAT_DONE_BIT]) begin
            $display("%s: the divider never reported done", name);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (n_errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, n_errors - errs_before);
            n_failed_tests++;
        end
    endtask

    task automatic run_division(input string name, input div_pkg::div_mode_e mode,
                                input logic irq_en, input div_pkg::word_t dvd,
                                input div_pkg::word_t dvs, input div_pkg::word_t exp_q,
                                input div_pkg::word_t exp_r);
        div_pkg::word_t ctrl;
        div_pkg::word_t status;
        div_pkg::word_t quo;
        div_pkg::word_t rem;
        int             errs_before;
        errs_before                   = n_errors;
        ctrl                          = '0;
        ctrl[div_pkg::CTRL_MODE_BIT]   = mode;
        ctrl[div_pkg::CTRL_IRQ_EN_BIT] = irq_en;
        wb_write(div_pkg::REG_DIVIDEND, dvd);
        wb_write(div_pkg::REG_DIVISOR, dvs);
        wb_write(div_pkg::REG_CTRL, ctrl);
        @(negedge clk_i);
        check_irq({name, " irq after start"}, 1'b0); // sticky done cleared by start
        wait_done(name, status);
        check_status(name, 1'b0, 1'b1, status);
        wb_read(div_pkg::REG_QUOTIENT, quo);
        wb_read(div_pkg::REG_REMAINDER, rem);
        check_word({name, " quotient"}, exp_q, quo);
        check_word({name, " remainder"}, exp_r, rem);
        @(negedge clk_i);
        check_irq({name, " irq after done"}, irq_en);
        report_test(name, errs_before);
    endtask

    // second control write lands while the core is still iterating
    task automatic busy_test();
        div_pkg::word_t dvd;
        div_pkg::word_t dvs;
        div_pkg::word_t status;
        div_pkg::word_t quo;
        div_pkg::word_t rem;
        div_pkg::word_t ctrl_rd;
        int             errs_before;
        errs_before = n_errors;
        dvd         = 32'h00ff_ffff;
        dvs         = 32'h0000_0013;
        wb_write(div_pkg::REG_DIVIDEND, dvd);
        wb_write(div_pkg::REG_DIVISOR, dvs);
        wb_write(div_pkg::REG_CTRL, 32'h0);
        wb_read(div_pkg::REG_STATUS, status);
        check_status("busy after start", 1'b1, 1'b0, status);
        wb_write(div_pkg::REG_DIVIDEND, 32'h0000_0005);
        wb_write(div_pkg::REG_DIVISOR, 32'h0000_0001);
        wb_write(div_pkg::REG_CTRL, 32'h0000_0003); // signed with irq on
        wait_done("busy control write", status);
        check_status("busy control write", 1'b0, 1'b1, status);
        wb_read(div_pkg::REG_QUOTIENT, quo);
        wb_read(div_pkg::REG_REMAINDER, rem);
        wb_read(div_pkg::REG_CTRL, ctrl_rd);
        check_word("busy control write quotient", dvd / dvs, quo);
        check_word("busy control write remainder", dvd % dvs, rem);
        check_word("busy control write ctrl", 32'h0, ctrl_rd);
        @(negedge clk_i);
        check_irq("busy control write irq", 1'b0);
        report_test("busy control write", errs_before);
    endtask

    initial begin
        string          line;
        int             fd;
        int             rc;
        logic [31:0]    m;
        div_pkg::word_t a;
        div_pkg::word_t b;
        div_pkg::word_t q;
        div_pkg::word_t r;
        div_pkg::word_t dvd;
        div_pkg::word_t dvs;
        rst_i    = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        seed     = 32'h3d11;
        fd = $fopen("div_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file div_patterns.txt");
            n_errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                rc = $sscanf(line, "%h %h %h %h %h", m, a, b, q, r);
                if (rc == 5) begin // comment lines do not parse
                    pat_mode.push_back(div_pkg::div_mode_e'(m[0]));
                    pat_dvd.push_back(a);
                    pat_dvs.push_back(b);
                    pat_quo.push_back(q);
                    pat_rem.push_back(r);
                end
            end
            $fclose(fd);
            if (pat_dvd.size() == 0) begin
                $display("no test lines found in div_patterns.txt");
                n_errors++;
            end
        end
        n_tests = pat_dvd.size() + N_RANDOM + 1;

        repeat (10) @(posedge clk_i);
        rst_i <= 1'b1;

        for (int i = 0; i < pat_dvd.size(); i++) begin
            run_division($sformatf("pattern %0d", i), pat_mode[i], i[0],
                         pat_dvd[i], pat_dvs[i], pat_quo[i], pat_rem[i]);
        end
        busy_test();
        for (int i = 0; i < N_RANDOM; i++) begin
            dvd = $random(seed);
            dvs = $random(seed);
            dvs = dvs >> dvs[4:0]; // spread divisor sizes
            if (dvs == '0) begin
                dvs = 32'h1;
            end
            run_division($sformatf("random %0d", i), div_pkg::DIV_UNSIGNED, i[0],
                         dvd, dvs, dvd / dvs, dvd % dvs);
        end

        $display("%0d tests, %0d failed, %0d check errors", n_tests, n_failed_tests, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== div_patterns.txt ====
# mode dividend divisor quotient remainder, all in hex
# mode 0 is unsigned, mode 1 is signed
0 00000064 00000007 0000000e 00000002
0 ffffffff 00000010 0fffffff 0000000f
0 80000000 00000003 2aaaaaaa 00000002
0 deadbeef 00001000 000deadb 00000eef
0 12345678 12345678 00000001 00000000
0 fffffffe ffffffff 00000000 fffffffe
0 00000005 00000009 00000000 00000005
0 0000abcd 00000000 ffffffff 0000abcd
0 87654321 00000001 87654321 00000000
1 00000064 00000007 0000000e 00000002
1 ffffff9c 00000007 fffffff2 fffffffe
1 00000064 fffffff9 fffffff2 00000002
1 ffffff9c fffffff9 0000000e fffffffe
1 00000007 ffffff9c 00000000 00000007
1 80000000 00000001 80000000 00000000
1 80000000 ffffffff 80000000 00000000
1 80000000 00000002 c0000000 00000000
1 fffffff6 00000000 ffffffff fffffff6
1 7fffffff ffffffff 80000001 00000000
1 fffffff9 00000002 fffffffd ffffffff
1 80000001 00000010 f8000001 fffffff1
1 00000000 00000005 00000000 00000000

// ==== src.f ====
div_pkg.sv
div_if.sv
div_core.sv
div_regs.sv
div_top.sv
div_properties.sv
tb_div_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=tb_div_top_sim

verilator --binary --assert -f src.f --top-module tb_div_top -o "$SIM"
if [ $? -ne 0 ]; then
    echo "build error"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
